//--- rtl/lcd_pkg.sv
package lcd_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int STAGE_W = 3;
    localparam int DELAY_W = 20;
    localparam int PHASE_W = 3;
    localparam int STEP_W  = 4;

    ////////////////////////////////////////
    // bus timing, in clock cycles
    ////////////////////////////////////////

    localparam logic [DELAY_W-1:0] E_HIGH_CYCLES       = 20'd13;
    localparam logic [DELAY_W-1:0] NIBBLE_GAP_CYCLES   = 20'd51;
    localparam logic [DELAY_W-1:0] SETTLE_CYCLES       = 20'd2001;
    localparam logic [DELAY_W-1:0] CLEAR_SETTLE_CYCLES = 20'd82001;
    localparam logic [DELAY_W-1:0] POWER_ON_CYCLES     = 20'd750001;
    // on top of the normal settle time
    localparam logic [DELAY_W-1:0] WAKE_EXTRA_1_CYCLES = 20'd203000;
    localparam logic [DELAY_W-1:0] WAKE_EXTRA_2_CYCLES = 20'd3000;

    ////////////////////////////////////////
    // controller codes
    ////////////////////////////////////////

    localparam logic [3:0] WAKE_NIBBLE       = 4'h3;
    localparam logic [3:0] FOUR_BIT_NIBBLE   = 4'h2;
    localparam logic [7:0] CMD_FUNCTION_SET  = 8'h28;
    localparam logic [7:0] CMD_ENTRY_MODE    = 8'h06;
    localparam logic [7:0] CMD_DISPLAY_ON    = 8'h0c;
    localparam logic [7:0] CMD_CLEAR         = 8'h01;
    localparam logic [7:0] CMD_HOME_ADDR     = 8'h80;

    // writer phases
    localparam logic [PHASE_W-1:0] PH_IDLE   = 3'd0;
    localparam logic [PHASE_W-1:0] PH_HIGH   = 3'd1;
    localparam logic [PHASE_W-1:0] PH_GAP    = 3'd2;
    localparam logic [PHASE_W-1:0] PH_LOW    = 3'd3;
    localparam logic [PHASE_W-1:0] PH_SETTLE = 3'd4;

    // sequencer steps, request steps are consecutive where possible
    localparam logic [STEP_W-1:0] ST_POWER   = 4'd0;
    localparam logic [STEP_W-1:0] ST_WAKE1   = 4'd1;
    localparam logic [STEP_W-1:0] ST_WAIT1   = 4'd2;
    localparam logic [STEP_W-1:0] ST_WAKE2   = 4'd3;
    localparam logic [STEP_W-1:0] ST_WAIT2   = 4'd4;
    localparam logic [STEP_W-1:0] ST_WAKE3   = 4'd5;
    localparam logic [STEP_W-1:0] ST_FOUR    = 4'd6;
    localparam logic [STEP_W-1:0] ST_FUNC    = 4'd7;
    localparam logic [STEP_W-1:0] ST_ENTRY   = 4'd8;
    localparam logic [STEP_W-1:0] ST_DISP    = 4'd9;
    localparam logic [STEP_W-1:0] ST_CLEAR   = 4'd10;
    localparam logic [STEP_W-1:0] ST_ADDR    = 4'd11;
    localparam logic [STEP_W-1:0] ST_CHAR_HI = 4'd12;
    localparam logic [STEP_W-1:0] ST_CHAR_LO = 4'd13;
    localparam logic [STEP_W-1:0] ST_WATCH   = 4'd14;

endpackage

//--- rtl/lcd_nibble_writer.sv
`timescale 1ns/1ps

module lcd_nibble_writer (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  logic [7:0] req_byte,
    input  logic       req_rs,
    input  logic       req_nibble_only,
    output logic       req_ready,
    output logic [3:0] lcd_data,
    output logic       lcd_e,
    output logic       lcd_rs
);

    logic [lcd_pkg::PHASE_W-1:0] phase;
    logic [lcd_pkg::DELAY_W-1:0] cnt;
    logic [lcd_pkg::DELAY_W-1:0] settle_len;
    logic [3:0]                  low_nibble;
    logic                        nibble_only;
    logic                        long_settle;
    logic                        accept;

    assign req_ready = (phase == lcd_pkg::PH_IDLE);
    assign accept    = req_valid && req_ready;

    // clear needs the long execution time
    assign settle_len = long_settle ? lcd_pkg::CLEAR_SETTLE_CYCLES : lcd_pkg::SETTLE_CYCLES;

    ////////////////////////////////////////
    // request capture
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            low_nibble  <= req_byte[3:0];
            nibble_only <= req_nibble_only;
            long_settle <= !req_rs && !req_nibble_only && (req_byte == lcd_pkg::CMD_CLEAR);
        end
    end

    ////////////////////////////////////////
    // pulse generation
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= lcd_pkg::PH_IDLE;
            cnt      <= '0;
            lcd_e    <= 1'b0;
            lcd_rs   <= 1'b0;
            lcd_data <= 4'h0;
        end else begin
            case (phase)
                lcd_pkg::PH_IDLE: begin
                    if (accept) begin
                        phase    <= lcd_pkg::PH_HIGH;
                        cnt      <= '0;
                        lcd_e    <= 1'b1;
                        lcd_rs   <= req_rs;
                        // single nibbles sit in the low half of the byte
                        lcd_data <= req_nibble_only ? req_byte[3:0] : req_byte[7:4];
                    end
                end

                lcd_pkg::PH_HIGH: begin
                    if (cnt == lcd_pkg::E_HIGH_CYCLES - 1'b1) begin
                        lcd_e <= 1'b0;
                        cnt   <= '0;
                        phase <= nibble_only ? lcd_pkg::PH_SETTLE : lcd_pkg::PH_GAP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end

                lcd_pkg::PH_GAP: begin
                    if (cnt == lcd_pkg::NIBBLE_GAP_CYCLES - 1'b1) begin
                        lcd_e    <= 1'b1;
                        lcd_data <= low_nibble;
                        cnt      <= '0;
                        phase    <= lcd_pkg::PH_LOW;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end

                lcd_pkg::PH_LOW: begin
                    if (cnt == lcd_pkg::E_HIGH_CYCLES - 1'b1) begin
                        lcd_e <= 1'b0;
                        cnt   <= '0;
                        phase <= lcd_pkg::PH_SETTLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end

                lcd_pkg::PH_SETTLE: begin
                    if (cnt == settle_len - 1'b1) begin
                        cnt   <= '0;
                        phase <= lcd_pkg::PH_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end

                default: begin
                    phase <= lcd_pkg::PH_IDLE;
                    lcd_e <= 1'b0;
                end
            endcase
        end
    end

    // every enable pulse ends exactly after the high time
    assert property (@(posedge clk) disable iff (rst)
        $rose(lcd_e) |-> ##(lcd_pkg::E_HIGH_CYCLES) !lcd_e);

    // sequencer keeps a pending request steady
    assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req_byte) && $stable(req_rs)
            && $stable(req_nibble_only));

endmodule

//--- rtl/lcd_sequencer.sv
`timescale 1ns/1ps

module lcd_sequencer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [lcd_pkg::STAGE_W-1:0] stage,
    input  logic [7:0]                  char_hi,
    input  logic [7:0]                  char_lo,
    input  logic                        req_ready,
    output logic [lcd_pkg::STAGE_W-1:0] shown_stage,
    output logic                        req_valid,
    output logic [7:0]                  req_byte,
    output logic                        req_rs,
    output logic                        req_nibble_only
);

    logic [lcd_pkg::STEP_W-1:0]  step;
    logic [lcd_pkg::DELAY_W-1:0] cnt;
    logic [lcd_pkg::STAGE_W-1:0] stage_q;

    ////////////////////////////////////////
    // request decode
    ////////////////////////////////////////

    always_comb begin
        req_valid       = 1'b1;
        req_byte        = 8'h00;
        req_rs          = 1'b0;
        req_nibble_only = 1'b0;
        case (step)
            lcd_pkg::ST_WAKE1, lcd_pkg::ST_WAKE2, lcd_pkg::ST_WAKE3: begin
                req_byte        = {4'h0, lcd_pkg::WAKE_NIBBLE};
                req_nibble_only = 1'b1;
            end
            lcd_pkg::ST_FOUR: begin
                req_byte        = {4'h0, lcd_pkg::FOUR_BIT_NIBBLE};
                req_nibble_only = 1'b1;
            end
            lcd_pkg::ST_FUNC: begin
                req_byte = lcd_pkg::CMD_FUNCTION_SET;
            end
            lcd_pkg::ST_ENTRY: begin
                req_byte = lcd_pkg::CMD_ENTRY_MODE;
            end
            lcd_pkg::ST_DISP: begin
                req_byte = lcd_pkg::CMD_DISPLAY_ON;
            end
            lcd_pkg::ST_CLEAR: begin
                req_byte = lcd_pkg::CMD_CLEAR;
            end
            lcd_pkg::ST_ADDR: begin
                req_byte = lcd_pkg::CMD_HOME_ADDR;
            end
            lcd_pkg::ST_CHAR_HI: begin
                req_byte = char_hi;
                req_rs   = 1'b1;
            end
            lcd_pkg::ST_CHAR_LO: begin
                req_byte = char_lo;
                req_rs   = 1'b1;
            end
            default: begin
                req_valid = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////
    // step control
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step        <= lcd_pkg::ST_POWER;
            cnt         <= '0;
            stage_q     <= '0;
            shown_stage <= '0;
        end else begin
            stage_q <= stage;
            case (step)
                lcd_pkg::ST_POWER: begin
                    if (cnt == lcd_pkg::POWER_ON_CYCLES - 1'b1) begin
                        cnt  <= '0;
                        step <= lcd_pkg::ST_WAKE1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end

                // extra wake waits start once the writer has settled
                lcd_pkg::ST_WAIT1: begin
                    if (req_ready) begin
                        if (cnt == lcd_pkg::WAKE_EXTRA_1_CYCLES - 1'b1) begin
                            cnt  <= '0;
                            step <= lcd_pkg::ST_WAKE2;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end

                lcd_pkg::ST_WAIT2: begin
                    if (req_ready) begin
                        if (cnt == lcd_pkg::WAKE_EXTRA_2_CYCLES - 1'b1) begin
                            cnt  <= '0;
                            step <= lcd_pkg::ST_WAKE3;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end

                lcd_pkg::ST_DISP: begin
                    if (req_ready) begin
                        step        <= lcd_pkg::ST_CLEAR;
                        shown_stage <= stage_q;
                    end
                end

                lcd_pkg::ST_CHAR_LO: begin
                    if (req_ready) begin
                        step <= lcd_pkg::ST_WATCH;
                    end
                end

                // latest sampled code wins, skipped codes are never shown
                lcd_pkg::ST_WATCH: begin
                    if (req_ready && (stage_q != shown_stage)) begin
                        step        <= lcd_pkg::ST_CLEAR;
                        shown_stage <= stage_q;
                    end
                end

                lcd_pkg::ST_WAKE1, lcd_pkg::ST_WAKE2, lcd_pkg::ST_WAKE3,
                lcd_pkg::ST_FOUR, lcd_pkg::ST_FUNC, lcd_pkg::ST_ENTRY,
                lcd_pkg::ST_CLEAR, lcd_pkg::ST_ADDR, lcd_pkg::ST_CHAR_HI: begin
                    if (req_ready) begin
                        step <= step + 1'b1;
                    end
                end

                default: begin
                    step <= lcd_pkg::ST_POWER;
                    cnt  <= '0;
                end
            endcase
        end
    end

    // no request goes out while a wait is still counting
    assert property (@(posedge clk) disable iff (rst)
        req_valid |-> cnt == '0);

endmodule

//--- rtl/stage_name_rom.sv
`timescale 1ns/1ps

module stage_name_rom (
    input  logic [lcd_pkg::STAGE_W-1:0] code,
    output logic [7:0]                  char_hi,
    output logic [7:0]                  char_lo
);

    // two ascii characters per pipeline stage
    always_comb begin
        case (code)
            3'd0: begin
                char_hi = "G";
                char_lo = "O";
            end
            3'd1: begin
                char_hi = "I";
                char_lo = "F";
            end
            3'd2: begin
                char_hi = "I";
                char_lo = "D";
            end
            3'd3: begin
                char_hi = "E";
                char_lo = "X";
            end
            3'd4: begin
                char_hi = "M";
                char_lo = "E";
            end
            3'd5: begin
                char_hi = "W";
                char_lo = "B";
            end
            // codes 6 and 7 have no stage
            default: begin
                char_hi = "-";
                char_lo = "-";
            end
        endcase
    end

endmodule

//--- rtl/lcd_stage_display.sv
`timescale 1ns/1ps

module lcd_stage_display (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [lcd_pkg::STAGE_W-1:0] stage,
    output logic [3:0]                  lcd_data,
    output logic                        lcd_e,
    output logic                        lcd_rs
);

    logic [lcd_pkg::STAGE_W-1:0] shown_stage;
    logic [7:0]                  char_hi;
    logic [7:0]                  char_lo;
    logic                        req_valid;
    logic                        req_ready;
    logic [7:0]                  req_byte;
    logic                        req_rs;
    logic                        req_nibble_only;

    lcd_sequencer lcd_sequencer_i (
        .clk             (clk),
        .rst             (rst),
        .stage           (stage),
        .char_hi         (char_hi),
        .char_lo         (char_lo),
        .req_ready       (req_ready),
        .shown_stage     (shown_stage),
        .req_valid       (req_valid),
        .req_byte        (req_byte),
        .req_rs          (req_rs),
        .req_nibble_only (req_nibble_only)
    );

    stage_name_rom stage_name_rom_i (
        .code    (shown_stage),
        .char_hi (char_hi),
        .char_lo (char_lo)
    );

    lcd_nibble_writer lcd_nibble_writer_i (
        .clk             (clk),
        .rst             (rst),
        .req_valid       (req_valid),
        .req_byte        (req_byte),
        .req_rs          (req_rs),
        .req_nibble_only (req_nibble_only),
        .req_ready       (req_ready),
        .lcd_data        (lcd_data),
        .lcd_e           (lcd_e),
        .lcd_rs          (lcd_rs)
    );

endmodule

//--- verification/lcd_bus_monitor.sv
`timescale 1ns/1ps

module lcd_bus_monitor (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] lcd_data,
    input  logic       lcd_e,
    input  logic       lcd_rs,
    output logic       byte_seen,
    output logic [7:0] seen_data,
    output logic       seen_rs,
    output logic       seen_single,
    output logic       mid_byte
);

    logic       e_q;
    logic [3:0] data_q;
    logic       rs_q;
    logic [2:0] singles_left;
    logic [3:0] high_nibble;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            e_q          <= 1'b0;
            data_q       <= 4'h0;
            rs_q         <= 1'b0;
            singles_left <= 3'd4;
            high_nibble  <= 4'h0;
            mid_byte     <= 1'b0;
            byte_seen    <= 1'b0;
            seen_data    <= 8'h00;
            seen_rs      <= 1'b0;
            seen_single  <= 1'b0;
        end else begin
            e_q       <= lcd_e;
            data_q    <= lcd_data;
            rs_q      <= lcd_rs;
            byte_seen <= 1'b0;
            // falling enable, nibble was sampled one cycle earlier
            if (e_q && !lcd_e) begin
                if (singles_left != 3'd0) begin
                    // wake-up nibbles stand alone
                    singles_left <= singles_left - 3'd1;
                    byte_seen    <= 1'b1;
                    seen_data    <= {4'h0, data_q};
                    seen_rs      <= rs_q;
                    seen_single  <= 1'b1;
                end else if (!mid_byte) begin
                    mid_byte    <= 1'b1;
                    high_nibble <= data_q;
                end else begin
                    mid_byte    <= 1'b0;
                    byte_seen   <= 1'b1;
                    seen_data   <= {high_nibble, data_q};
                    seen_rs     <= rs_q;
                    seen_single <= 1'b0;
                end
            end
        end
    end

endmodule

//--- verification/lcd_stage_display_tb.sv
`timescale 1ns/1ps

module lcd_stage_display_tb;

    logic                        clk;
    logic                        rst;
    logic [lcd_pkg::STAGE_W-1:0] stage;
    logic [3:0]                  lcd_data;
    logic                        lcd_e;
    logic                        lcd_rs;
    logic                        byte_seen;
    logic [7:0]                  seen_data;
    logic                        seen_rs;
    logic                        seen_single;
    logic                        mid_byte;

    // entries are {single, rs, data}
    logic [9:0]  exp_q[$];
    logic [9:0]  exp_head;
    int          exp_count;
    int          high_len;
    int          low_len;
    int          min_low;
    int          transfers;
    int          errors;
    int          errors_before;
    int          tests_passed;
    int          tests_failed;
    bit          timed_out;
    integer      seed;
    logic [15:0] names [8] = '{"GO", "IF", "ID", "EX", "ME", "WB", "--", "--"};
    logic [2:0]  order [8];
    logic [2:0]  shown;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    lcd_stage_display lcd_stage_display_i (
        .clk      (clk),
        .rst      (rst),
        .stage    (stage),
        .lcd_data (lcd_data),
        .lcd_e    (lcd_e),
        .lcd_rs   (lcd_rs)
    );

    lcd_bus_monitor lcd_bus_monitor_i (
        .clk         (clk),
        .rst         (rst),
        .lcd_data    (lcd_data),
        .lcd_e       (lcd_e),
        .lcd_rs      (lcd_rs),
        .byte_seen   (byte_seen),
        .seen_data   (seen_data),
        .seen_rs     (seen_rs),
        .seen_single (seen_single),
        .mid_byte    (mid_byte)
    );

    // minimum enable low time that must follow a transfer
    function automatic int settle_after(input int index, input logic [9:0] seen);
        if (index == 0) begin
            return int'(lcd_pkg::SETTLE_CYCLES) + int'(lcd_pkg::WAKE_EXTRA_1_CYCLES);
        end else if (index == 1) begin
            return int'(lcd_pkg::SETTLE_CYCLES) + int'(lcd_pkg::WAKE_EXTRA_2_CYCLES);
        end else if (seen == {2'b00, lcd_pkg::CMD_CLEAR}) begin
            return int'(lcd_pkg::CLEAR_SETTLE_CYCLES);
        end
        return int'(lcd_pkg::SETTLE_CYCLES);
    endfunction

    ////////////////////////////////////////
    // bus bookkeeping
    ////////////////////////////////////////

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            high_len  <= 0;
            low_len   <= 0;
            min_low   <= int'(lcd_pkg::POWER_ON_CYCLES);
            transfers <= 0;
        end else begin
            if (lcd_e) begin
                high_len <= high_len + 1;
                low_len  <= 0;
            end else begin
                high_len <= 0;
                low_len  <= low_len + 1;
            end
            if (byte_seen) begin
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
                transfers <= transfers + 1;
                min_low   <= settle_after(transfers, {seen_single, seen_rs, seen_data});
            end
        end
    end

    // head of the list moves away from the sampling edge
    always @(negedge clk) begin
        exp_count <= exp_q.size();
        if (exp_q.size() != 0) begin
            exp_head <= exp_q[0];
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst)
        $fell(lcd_e) |-> high_len == int'(lcd_pkg::E_HIGH_CYCLES))
    else begin
        $display("** Error %0t: enable high for %0d cycles", $time, high_len);
        errors++;
    end

    assert property (@(posedge clk) disable iff (rst)
        lcd_e && $past(lcd_e) |-> $stable(lcd_data) && $stable(lcd_rs))
    else begin
        $display("** Error %0t: data or rs changed while enable was high", $time);
        errors++;
    end

    assert property (@(posedge clk) disable iff (rst)
        $rose(lcd_e) && mid_byte |-> low_len == int'(lcd_pkg::NIBBLE_GAP_CYCLES))
    else begin
        $display("** Error %0t: nibble gap of %0d cycles", $time, low_len);
        errors++;
    end

    // power-on delay, wake waits and settle times
    assert property (@(posedge clk) disable iff (rst)
        $rose(lcd_e) && !mid_byte |-> low_len >= min_low)
    else begin
        $display("** Error %0t: enable low %0d cycles, need %0d", $time, low_len, min_low);
        errors++;
    end

    assert property (@(posedge clk) disable iff (rst)
        byte_seen |-> exp_count != 0)
    else begin
        $display("a transfer appeared on the LCD bus when none was expected");
        errors++;
    end

    assert property (@(posedge clk) disable iff (rst)
        byte_seen && exp_count != 0 |-> {seen_single, seen_rs, seen_data} == exp_head)
    else begin
        $display("** Error %0t: transfer %h, expected %h", $time,
            {seen_single, seen_rs, seen_data}, exp_head);
        errors++;
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic expect_nibble(input logic [3:0] nibble);
        exp_q.push_back({2'b10, 4'h0, nibble});
    endtask

    task automatic expect_byte(input logic rs, input logic [7:0] data);
        exp_q.push_back({1'b0, rs, data});
    endtask

    task automatic expect_update(input logic [2:0] code);
        logic [15:0] name;
        name = names[code];
        expect_byte(1'b0, lcd_pkg::CMD_CLEAR);
        expect_byte(1'b0, lcd_pkg::CMD_HOME_ADDR);
        expect_byte(1'b1, name[15:8]);
        expect_byte(1'b1, name[7:0]);
    endtask

    // returns once at most left transfers are still expected
    task automatic wait_for_transfers(input int left, input int limit);
        int cycles;
        cycles = 0;
        while (!timed_out && exp_q.size() > left) begin
            @(negedge clk);
            cycles++;
            if (cycles >= limit) begin
                $display("timeout: %0d expected transfers never appeared", exp_q.size());
                timed_out = 1'b1;
                errors++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial begin
        int         j;
        int         r;
        logic [2:0] tmp;
        logic [2:0] first;
        seed          = 32'h3657_7919;
        errors        = 0;
        errors_before = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        timed_out     = 1'b0;
        // shuffled codes, the last one is shown first
        for (int i = 0; i < 8; i++) begin
            order[i] = 3'(i);
        end
        for (int i = 7; i > 0; i--) begin
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        shown = order[7];
        stage = shown;
        rst   = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        assert (!lcd_e && !lcd_rs && lcd_data == 4'h0)
        else begin
            $display("** Error %0t: LCD pins not low after reset", $time);
            errors++;
        end
        repeat (3) expect_nibble(lcd_pkg::WAKE_NIBBLE);
        expect_nibble(lcd_pkg::FOUR_BIT_NIBBLE);
        expect_byte(1'b0, lcd_pkg::CMD_FUNCTION_SET);
        expect_byte(1'b0, lcd_pkg::CMD_ENTRY_MODE);
        expect_byte(1'b0, lcd_pkg::CMD_DISPLAY_ON);
        expect_update(shown);
        wait_for_transfers(0, int'(lcd_pkg::POWER_ON_CYCLES) + 400000);
        finish_test("power-up and init");

        for (int k = 0; k < 8; k++) begin
            repeat (int'(lcd_pkg::SETTLE_CYCLES) + 2) @(negedge clk);
            stage = order[k];
            expect_update(order[k]);
            wait_for_transfers(0, 2 * int'(lcd_pkg::CLEAR_SETTLE_CYCLES));
        end
        shown = order[7];
        finish_test("all stage codes");

        // two more changes while one update runs
        repeat (int'(lcd_pkg::SETTLE_CYCLES) + 2) @(negedge clk);
        r     = $unsigned($random(seed)) % 7;
        first = shown ^ 3'(r + 1);
        stage = first;
        expect_update(first);
        wait_for_transfers(3, 2 * int'(lcd_pkg::CLEAR_SETTLE_CYCLES));
        stage = first ^ 3'd1;
        repeat (int'(lcd_pkg::SETTLE_CYCLES)) @(negedge clk);
        stage = first ^ 3'd6;
        expect_update(first ^ 3'd6);
        wait_for_transfers(0, 4 * int'(lcd_pkg::CLEAR_SETTLE_CYCLES));
        repeat (3 * int'(lcd_pkg::SETTLE_CYCLES)) @(negedge clk);
        finish_test("double change");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/lcd_pkg.sv
rtl/lcd_nibble_writer.sv
rtl/lcd_sequencer.sv
rtl/stage_name_rom.sv
rtl/lcd_stage_display.sv
verification/lcd_bus_monitor.sv
verification/lcd_stage_display_tb.sv

//--- run.sh
#!/bin/sh
# build and run the LCD stage display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f \
    --top-module lcd_stage_display_tb \
    --Mdir obj_dir -o sim

./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
    echo "simulation PASSED"
else
    echo "simulation FAILED"
    exit 1
fi
